//--- all.f
+incdir+include
hdl/ppu_cfg_pkg.sv
hdl/ppu_bus_pkg.sv
hdl/ppu_vram.sv
hdl/ppu_pixel_gearbox.sv
hdl/ppu_background.sv
hdl/ppu_bg_top.sv
tb/tb_clkgen.sv
tb/tb_ppu_bg.sv

//--- Bender.yml
package:
  name: ppu_bg

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/ppu_cfg_pkg.sv
      - hdl/ppu_bus_pkg.sv
      - hdl/ppu_vram.sv
      - hdl/ppu_pixel_gearbox.sv
      - hdl/ppu_background.sv
      - hdl/ppu_bg_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_clkgen.sv
      - tb/tb_ppu_bg.sv

//--- tb/tb_ppu_bg.sv
/*
 * Testbench for the background layer top level. It loads video
 * memory with random words, then applies a table of rows, each one a
 * configuration and beam position started by a flush. Every pixel is
 * compared with a model built from the tilemap and tileset rules,
 * and the credit count is watched against its limit.
 */
`include "ppu_consts.svh"

module tb_ppu_bg import ppu_cfg_pkg::*, ppu_bus_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	// One row of the stimulus table. A positive abort_cyc cuts the row
	// short with the next flush after that many cycles
	typedef struct {
		bg_cfg_t cfg;
		int      beam_y;
		int      beam_x;
		int      npix;
		int      cdelay;
		int      abort_cyc;
	} row_t;

	logic                    clk;
	logic                    rst_n;
	logic                    en;
	logic                    flush;
	logic [`PPU_W_COORD-1:0] beam_x;
	logic [`PPU_W_COORD-1:0] beam_y;
	bg_cfg_t                 cfg;
	vram_wr_t                vram_wr;
	logic                    out_vld;
	pixel_t                  out_pix;
	logic                    credit_ret;

	logic [`PPU_W_DATA-1:0]  vram_model [`PPU_VRAM_WORDS];
	row_t                    rows [$];
	int                      credit_due [$];
	integer                  seed = 96394;
	bit                      table_ready = 1'b0;
	int                      cur_row = -1;
	int                      row_sel = -1;
	int                      row_rx = 0;
	int                      outstanding = 0;
	int                      cycle = 0;
	pixel_t                  exp_pix;

	tb_clkgen #(.PERIOD_NS(20), .RST_CYCLES(16)) clkgen_inst (.clk(clk), .rst_n(rst_n));

	ppu_bg_top ppu_bg_top_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.en         (en),
		.flush      (flush),
		.beam_x     (beam_x),
		.beam_y     (beam_y),
		.cfg        (cfg),
		.vram_wr    (vram_wr),
		.out_vld    (out_vld),
		.out_pix    (out_pix),
		.credit_ret (credit_ret)
	);

	// ------------------------------------------------------------------
	// Reference model and checks

	task automatic abort_run();
		$display("TB FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_pixel(string name, pixel_t got, pixel_t exp);
		if (got !== exp) begin
			$display({"CHECK FAILED at %0t: %s got alpha %0b idx 0x%02h,",
				" expected alpha %0b idx 0x%02h"},
				$time, name, got.alpha, got.idx, exp.alpha, exp.idx);
			abort_run();
		end
	endtask

	task automatic check_credit(string name, int got, int limit);
		if (got > limit) begin
			$display("CHECK FAILED at %0t: %s is %0d, limit %0d",
				$time, name, got, limit);
			abort_run();
		end
	endtask

	// Pixel n of a row, straight from the tilemap and tileset rules
	function automatic pixel_t model_pixel(row_t r, int n);
		int          w;
		int          h;
		int          ts;
		int          bpp;
		int          u;
		int          v;
		int          byte_off;
		int          tile;
		int          bit_off;
		logic [31:0] word;
		pixel_t      p;
		w = 1 << r.cfg.log_w;
		h = 1 << r.cfg.log_h;
		ts = r.cfg.tile_size ? 16 : 8;
		bpp = 1 << r.cfg.pixel_mode;
		u = (r.beam_x + r.cfg.scroll_x + n) % w;
		v = (r.beam_y + r.cfg.scroll_y) % h;
		// Tilemap holds one byte per tile, w / ts bytes per map row
		byte_off = (v / ts) * (w / ts) + u / ts;
		word = vram_model[(r.cfg.tilemap_base + byte_off / 4) % `PPU_VRAM_WORDS];
		tile = (word >> (8 * (byte_off % 4))) & 32'hff;
		bit_off = ((tile * ts + v % ts) * ts + u % ts) * bpp;
		word = vram_model[(r.cfg.tileset_base + bit_off / 32) % `PPU_VRAM_WORDS];
		p.idx = `PPU_W_PIX'((word >> (bit_off % 32)) & ((1 << bpp) - 1));
		p.alpha = !(r.cfg.transparency && p.idx == 0);
		return p;
	endfunction

	// ------------------------------------------------------------------
	// Stimulus table

	function automatic bg_cfg_t make_cfg(int sx, int sy, int lw, int lh, int ts,
		pixel_mode_e pm, bit tr, int mapb, int setb);
		bg_cfg_t c;
		c.scroll_x = `PPU_W_COORD'(sx);
		c.scroll_y = `PPU_W_COORD'(sy);
		c.log_w = `PPU_W_LOG_COORD'(lw);
		c.log_h = `PPU_W_LOG_COORD'(lh);
		c.tile_size = (ts != 0);
		c.pixel_mode = pm;
		c.transparency = tr;
		c.tilemap_base = `PPU_W_VADDR'(mapb);
		c.tileset_base = `PPU_W_VADDR'(setb);
		return c;
	endfunction

	task automatic add_row(bg_cfg_t c, int by, int bx, int npix, int cdelay, int abort_cyc);
		row_t r;
		r.cfg = c;
		r.beam_y = by;
		r.beam_x = bx;
		r.npix = npix;
		r.cdelay = cdelay;
		r.abort_cyc = abort_cyc;
		rows.push_back(r);
	endtask

	task automatic build_table();
		// All four pixel sizes on 8x8 tiles across several words
		add_row(make_cfg(0, 0, 8, 6, 0, PIX_1, 0, 0, 64), 5, 0, 40, 1, 0);
		add_row(make_cfg(3, 0, 8, 6, 0, PIX_2, 0, 0, 64), 9, 2, 40, 2, 0);
		add_row(make_cfg(0, 7, 8, 6, 0, PIX_4, 0, 16, 128), 12, 4, 40, 1, 0);
		add_row(make_cfg(0, 0, 8, 6, 0, PIX_8, 0, 16, 128), 20, 6, 40, 3, 0);
		// Scroll close to the right and bottom edges, so u and v wrap
		add_row(make_cfg(60, 30, 6, 5, 0, PIX_4, 0, 512, 600), 4, 1, 24, 1, 0);
		// 16x16 tiles, with a wrap on the second one
		add_row(make_cfg(5, 0, 7, 7, 1, PIX_4, 0, 256, 300), 21, 0, 48, 1, 0);
		add_row(make_cfg(120, 100, 7, 7, 1, PIX_8, 0, 256, 300), 30, 0, 40, 2, 0);
		// Transparency on small pixels, where index 0 is frequent
		add_row(make_cfg(0, 0, 8, 6, 0, PIX_1, 1, 0, 64), 2, 0, 40, 1, 0);
		add_row(make_cfg(9, 0, 8, 6, 0, PIX_2, 1, 40, 200), 3, 0, 40, 1, 0);
		// Slow consumer, the stream has to stall at zero credits
		add_row(make_cfg(0, 0, 8, 6, 0, PIX_8, 1, 32, 96), 7, 0, 30, 25, 0);
		// Flushes that land on a read in flight, then one mid stream
		add_row(make_cfg(0, 0, 8, 6, 0, PIX_4, 0, 64, 400), 1, 0, 8, 1, 1);
		add_row(make_cfg(2, 0, 8, 6, 0, PIX_2, 0, 80, 450), 6, 0, 8, 1, 2);
		add_row(make_cfg(0, 4, 8, 6, 0, PIX_1, 0, 96, 500), 8, 0, 8, 1, 9);
		add_row(make_cfg(17, 3, 7, 7, 1, PIX_2, 0, 128, 700), 11, 5, 40, 2, 0);
	endtask

	// ------------------------------------------------------------------
	// Drivers

	task automatic fill_vram();
		logic [`PPU_W_DATA-1:0] word;
		for (int a = 0; a < `PPU_VRAM_WORDS; a++) begin
			word = $random(seed);
			@(posedge clk);
			vram_wr <= '{en: 1'b1, addr: `PPU_W_VADDR'(a), data: word};
			vram_model[a] = word;
		end
		@(posedge clk);
		vram_wr <= '0;
	endtask

	task automatic run_row(int r);
		@(posedge clk);
		cfg <= rows[r].cfg;
		beam_x <= `PPU_W_COORD'(rows[r].beam_x);
		beam_y <= `PPU_W_COORD'(rows[r].beam_y);
		flush <= 1'b1;
		cur_row = r;
		@(posedge clk);
		flush <= 1'b0;
		if (rows[r].abort_cyc > 0) begin
			repeat (rows[r].abort_cyc - 1) @(posedge clk);
		end else begin
			while (row_rx < rows[r].npix) @(posedge clk);
		end
	endtask

	// Consumer hands back one credit per cycle once its delay is over
	// and drops en two cycles in every sixteen to pause the stream
	always @(posedge clk) begin
		cycle++;
		en <= rst_n && (cycle % 16 >= 2);
		if (rst_n && credit_due.size() > 0 && credit_due[0] <= cycle) begin
			credit_ret <= 1'b1;
			void'(credit_due.pop_front());
		end else begin
			credit_ret <= 1'b0;
		end
	end

	// ------------------------------------------------------------------
	// The monitor samples mid cycle where every output has settled

	always @(negedge clk) begin
		if (rst_n) begin
			if (flush) begin
				row_sel = cur_row;
				row_rx = 0;
			end
			if (out_vld) begin
				if (!en) begin
					$display("A pixel came out at %0t while en was low", $time);
					abort_run();
				end
				if (row_sel < 0) begin
					$display("A pixel came out at %0t before any row was started", $time);
					abort_run();
				end
				exp_pix = model_pixel(rows[row_sel], row_rx);
				check_pixel($sformatf("out_pix (row %0d, pixel %0d)", row_sel, row_rx),
					out_pix, exp_pix);
				row_rx++;
				outstanding++;
				check_credit("outstanding pixels", outstanding, `PPU_OUT_CREDITS);
				credit_due.push_back(cycle + rows[row_sel].cdelay);
			end
			if (credit_ret) begin
				outstanding--;
			end
		end
	end

	// Budget covers the memory fill plus a generous time per pixel
	initial begin : watchdog
		int limit;
		wait (table_ready);
		limit = `PPU_VRAM_WORDS + 64;
		foreach (rows[r]) begin
			limit += rows[r].npix * 200 + 50;
		end
		repeat (limit) @(posedge clk);
		$display("Pixels stopped arriving: the run did not finish within %0d cycles", limit);
		abort_run();
	end

	initial begin : main
		en = 1'b0;
		flush = 1'b0;
		beam_x = '0;
		beam_y = '0;
		cfg = '0;
		vram_wr = '0;
		credit_ret = 1'b0;
		build_table();
		table_ready = 1'b1;
		wait (rst_n);
		@(posedge clk);
		fill_vram();
		foreach (rows[r]) begin
			run_row(r);
		end
		repeat (20) @(posedge clk);
		$display("TB PASSED");
		$finish;
	end

endmodule

//--- tb/tb_clkgen.sv
/*
 * Clock and reset source for the background layer testbench.
 * Gives a free running clock and holds reset low for a fixed number
 * of cycles, then releases it on a rising edge.
 */
module tb_clkgen #(
	parameter int PERIOD_NS  = 20,
	parameter int RST_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Reset leaves on a clock edge, like any other synchronous input
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

//--- hdl/ppu_bg_top.sv
/*
 * Top level of the background layer. Joins the fetch block to the
 * video memory and exposes the memory write port, the beam inputs,
 * the configuration and the credited pixel stream.
 */
`include "ppu_consts.svh"

module ppu_bg_top import ppu_cfg_pkg::*, ppu_bus_pkg::*; (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    en,
	input  logic                    flush,
	input  logic [`PPU_W_COORD-1:0] beam_x,
	input  logic [`PPU_W_COORD-1:0] beam_y,
	input  bg_cfg_t                 cfg,
	input  vram_wr_t                vram_wr,
	output logic                    out_vld,
	output pixel_t                  out_pix,
	input  logic                    credit_ret
);

	// Internal read path between fetch block and memory
	vram_req_t vram_req;
	vram_rsp_t vram_rsp;
	logic      vram_read_rdy;

	ppu_background background_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.en         (en),
		.flush      (flush),
		.beam_x     (beam_x),
		.beam_y     (beam_y),
		.cfg        (cfg),
		.req        (vram_req),
		.read_rdy   (vram_read_rdy),
		.rsp        (vram_rsp),
		.out_vld    (out_vld),
		.out_pix    (out_pix),
		.credit_ret (credit_ret)
	);

	ppu_vram vram_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr       (vram_wr),
		.req      (vram_req),
		.read_rdy (vram_read_rdy),
		.rsp      (vram_rsp)
	);

endmodule

//--- hdl/ppu_background.sv
/*
 * Background layer fetch and output. A flush latches the beam
 * position as a scrolled, wrapped background coordinate. The block
 * then reads the tile number from the tilemap, reads the tileset
 * word holding the pixel, and streams pixels out of the gearbox
 * while output credits last. Tile and word boundaries trigger
 * refetches. One memory read is outstanding at a time.
 */
`include "ppu_consts.svh"

module ppu_background import ppu_cfg_pkg::*, ppu_bus_pkg::*; (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    en,
	input  logic                    flush,
	input  logic [`PPU_W_COORD-1:0] beam_x,
	input  logic [`PPU_W_COORD-1:0] beam_y,
	input  bg_cfg_t                 cfg,
	output vram_req_t               req,
	input  logic                    read_rdy,
	input  vram_rsp_t               rsp,
	output logic                    out_vld,
	output pixel_t                  out_pix,
	input  logic                    credit_ret
);

	// Offsets are worked out wider than the memory, then cut to an address
	localparam int W_OFF  = 24;
	localparam int W_CRED = $clog2(`PPU_OUT_CREDITS + 1);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FETCH_TILE,
		ST_FETCH_PIX,
		ST_STREAM,
		ST_DISCARD
	} state_e;

	state_e                  state;
	state_e                  state_next;
	logic [`PPU_W_COORD-1:0] u;
	logic [`PPU_W_COORD-1:0] v;
	logic [7:0]              tile;
	logic [4:0]              tile_left;
	logic                    pending;
	logic                    rsp_hit;
	logic [`PPU_W_VADDR-1:0] hold_addr;
	logic [W_CRED-1:0]       credits;
	logic                    emit;
	logic                    tile_end;
	logic                    gb_load;
	logic                    gb_last;
	logic [`PPU_W_PIX-1:0]   gb_pix;

	// ------------------------------------------------------------------
	// Coordinates

	logic [2:0]              log_t;
	logic [4:0]              tile_pix;
	logic [`PPU_W_COORD-1:0] t_mask;
	logic [`PPU_W_COORD-1:0] w_mask;
	logic [`PPU_W_COORD-1:0] h_mask;
	logic [`PPU_W_COORD-1:0] col;
	logic [`PPU_W_COORD-1:0] row;

	assign log_t    = cfg.tile_size ? 3'd4 : 3'd3;
	assign tile_pix = 5'd8 << cfg.tile_size;
	assign t_mask   = `PPU_W_COORD'(tile_pix - 5'd1);

	// Background sizes are powers of two, so wrapping is a mask
	assign w_mask = ~({`PPU_W_COORD{1'b1}} << cfg.log_w);
	assign h_mask = ~({`PPU_W_COORD{1'b1}} << cfg.log_h);

	// Position of the pixel inside its tile
	assign col = u & t_mask;
	assign row = v & t_mask;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			u <= '0;
			v <= '0;
		end else if (flush) begin
			u <= (beam_x + cfg.scroll_x) & w_mask;
			v <= (beam_y + cfg.scroll_y) & h_mask;
		end else if (emit) begin
			// v holds for the whole row, only u moves
			u <= (u + 1'b1) & w_mask;
		end
	end

	// ------------------------------------------------------------------
	// Address generation

	logic [W_OFF-1:0]        map_off;
	logic [W_OFF-1:0]        pix_idx;
	logic [W_OFF-1:0]        bit_off;
	logic [`PPU_W_VADDR-1:0] tile_addr;
	logic [`PPU_W_VADDR-1:0] pix_addr;

	// Tilemap is one byte per tile, rows of width / tile size bytes
	assign map_off = (W_OFF'(v >> log_t) << (cfg.log_w - log_t)) + W_OFF'(u >> log_t);
	assign tile_addr = cfg.tilemap_base + map_off[`PPU_W_VADDR+1:2];

	// Tiles are stored back to back, each one row-major
	assign pix_idx = (((W_OFF'(tile) << log_t) | W_OFF'(row)) << log_t) | W_OFF'(col);
	assign bit_off = pix_idx << cfg.pixel_mode;
	assign pix_addr = cfg.tileset_base + bit_off[`PPU_W_VADDR+4:5];

	// ------------------------------------------------------------------
	// Memory requests

	// A request stays up until it is accepted, even across a flush.
	// In discard the pre-flush address is replayed so it does not move
	assign req.valid = (state == ST_FETCH_TILE || state == ST_FETCH_PIX ||
		state == ST_DISCARD) && !pending;
	assign req.addr = (state == ST_DISCARD) ? hold_addr :
		(state == ST_FETCH_TILE) ? tile_addr : pix_addr;

	always_ff @(posedge clk) begin
		if (state != ST_DISCARD) begin
			hold_addr <= req.addr;
		end
	end

	// An accepted read always answers on the next cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= 1'b0;
		end else begin
			pending <= req.valid && read_rdy;
		end
	end

	assign rsp_hit = pending && rsp.valid;

	// ------------------------------------------------------------------
	// Fetch sequencing

	assign tile_end = tile_left == 5'd1;

	always_comb begin
		state_next = state;
		if (flush) begin
			// A read still waiting for acceptance must be seen through first
			state_next = req.valid ? ST_DISCARD : ST_FETCH_TILE;
		end else begin
			case (state)
				ST_FETCH_TILE: if (rsp_hit) state_next = ST_FETCH_PIX;
				ST_FETCH_PIX:  if (rsp_hit) state_next = ST_STREAM;
				ST_STREAM: begin
					// A new tile always needs a new word, so it goes first
					if (emit && tile_end) begin
						state_next = ST_FETCH_TILE;
					end else if (emit && gb_last) begin
						state_next = ST_FETCH_PIX;
					end
				end
				ST_DISCARD:    if (rsp_hit) state_next = ST_FETCH_TILE;
				default:       state_next = state;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Tile number and pixels left in it, both set by the tilemap read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tile      <= 8'd0;
			tile_left <= 5'd0;
		end else if (state == ST_FETCH_TILE && rsp_hit) begin
			tile      <= rsp.data[{map_off[1:0], 3'b000} +: 8];
			tile_left <= tile_pix - col[4:0];
		end else if (emit) begin
			tile_left <= tile_left - 5'd1;
		end
	end

	assign gb_load = (state == ST_FETCH_PIX) && rsp_hit;

	ppu_pixel_gearbox gearbox_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.load       (gb_load),
		.din        (rsp.data),
		.start_bit  (bit_off[4:0]),
		.pixel_mode (cfg.pixel_mode),
		.advance    (emit),
		.pix        (gb_pix),
		.last       (gb_last)
	);

	// ------------------------------------------------------------------
	// Credited output

	// No pixel leaves in a flush cycle, it would belong to the old row
	assign emit = (state == ST_STREAM) && en && (credits != '0) && !flush;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credits <= W_CRED'(`PPU_OUT_CREDITS);
		end else begin
			credits <= credits + W_CRED'(credit_ret) - W_CRED'(emit);
		end
	end

	assign out_vld     = emit;
	assign out_pix.idx = gb_pix;
	// Index 0 is see-through only when transparency is on
	assign out_pix.alpha = !(cfg.transparency && gb_pix == '0);

endmodule

//--- hdl/ppu_pixel_gearbox.sv
/*
 * Pixel gearbox for the background layer. It holds one fetched word
 * and hands out one paletted pixel at a time, low bits first. A load
 * skips start_bit bits so the first pixel can sit anywhere in the
 * word. The pixel is on pix the cycle after load, and each advance
 * steps to the next one.
 */
`include "ppu_consts.svh"

module ppu_pixel_gearbox import ppu_cfg_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   load,
	input  logic [`PPU_W_DATA-1:0] din,
	input  logic [4:0]             start_bit,
	input  pixel_mode_e            pixel_mode,
	input  logic                   advance,
	output logic [`PPU_W_PIX-1:0]  pix,
	output logic                   last
);

	logic [`PPU_W_DATA-1:0] shreg;
	// Bit position of the current pixel within the original word
	logic [4:0]             pos;
	logic [5:0]             pix_bits;
	logic [`PPU_W_PIX-1:0]  pix_mask;

	assign pix_bits = 6'd1 << pixel_mode;

	always_comb begin
		case (pixel_mode)
			PIX_1:   pix_mask = 8'h01;
			PIX_2:   pix_mask = 8'h03;
			PIX_4:   pix_mask = 8'h0f;
			default: pix_mask = 8'hff;
		endcase
	end

	// A load puts the first wanted pixel at bit 0 and each advance drops one pixel
	always_ff @(posedge clk) begin
		if (load) begin
			shreg <= din >> start_bit;
		end else if (advance) begin
			shreg <= shreg >> pix_bits;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos <= 5'd0;
		end else if (load) begin
			pos <= start_bit;
		end else if (advance) begin
			// Wraps to zero past the last pixel of the word
			pos <= pos + pix_bits[4:0];
		end
	end

	assign pix = shreg[`PPU_W_PIX-1:0] & pix_mask;

	// Pixels are aligned to their own width, so the last one ends exactly at bit 32
	assign last = ({1'b0, pos} + pix_bits) == 6'd32;

endmodule

//--- hdl/ppu_vram.sv
/*
 * Single-ported video memory holding tilemap and tileset words.
 * The outside loads it through the write port; the background block
 * reads it. A write owns the port for its cycle, so read_rdy drops
 * and the read request is held over. Read data returns one cycle
 * after the request is accepted.
 */
`include "ppu_consts.svh"

module ppu_vram import ppu_bus_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  vram_wr_t  wr,
	input  vram_req_t req,
	output logic      read_rdy,
	output vram_rsp_t rsp
);

	logic [`PPU_W_DATA-1:0] mem [`PPU_VRAM_WORDS];
	logic                   read_acc;
	logic                   rsp_valid;
	logic [`PPU_W_DATA-1:0] rsp_data;

	// ------------------------------------------------------------------
	// Port arbitration

	// The single port is free for a read only when nobody is writing
	assign read_rdy = !wr.en;
	assign read_acc = req.valid && read_rdy;

	// ------------------------------------------------------------------
	// Storage

	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[wr.addr] <= wr.data;
		end
		// Read and write never share a cycle, so no bypass is needed
		if (read_acc) begin
			rsp_data <= mem[req.addr];
		end
	end

	// Response valid marks the cycle after an accepted read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= read_acc;
		end
	end

	assign rsp.valid = rsp_valid;
	assign rsp.data  = rsp_data;

endmodule

//--- hdl/ppu_bus_pkg.sv
/*
 * Types for the video memory port. The background block issues
 * read requests and receives responses; the outside loads memory
 * through the write type. Import it in modules that touch memory.
 */
`include "ppu_consts.svh"

package ppu_bus_pkg;

	// Read request, held by the requester until read_rdy is seen
	typedef struct packed {
		logic                    valid;
		logic [`PPU_W_VADDR-1:0] addr;
	} vram_req_t;

	// Read response, valid exactly one cycle after acceptance
	typedef struct packed {
		logic                   valid;
		logic [`PPU_W_DATA-1:0] data;
	} vram_rsp_t;

	// External write, takes priority over any read in the same cycle
	typedef struct packed {
		logic                    en;
		logic [`PPU_W_VADDR-1:0] addr;
		logic [`PPU_W_DATA-1:0]  data;
	} vram_wr_t;

endpackage

//--- hdl/ppu_cfg_pkg.sv
/*
 * Types that describe the background layer itself: how pixels are
 * packed in the tileset, the configuration word that positions the
 * background, and the pixel that leaves the block. Import it where
 * the configuration or output pixel is handled.
 */
`include "ppu_consts.svh"

package ppu_cfg_pkg;

	// Encoding is log2 of the pixel width in bits, so 1 << mode gives
	// the width directly
	typedef enum logic [1:0] {
		PIX_1 = 2'd0,
		PIX_2 = 2'd1,
		PIX_4 = 2'd2,
		PIX_8 = 2'd3
	} pixel_mode_e;

	// Background configuration, held stable by the outside while a
	// row is being drawn
	typedef struct packed {
		logic [`PPU_W_COORD-1:0]     scroll_x;
		logic [`PPU_W_COORD-1:0]     scroll_y;
		logic [`PPU_W_LOG_COORD-1:0] log_w;
		logic [`PPU_W_LOG_COORD-1:0] log_h;
		// 0 selects 8x8 tiles, 1 selects 16x16 tiles
		logic                        tile_size;
		pixel_mode_e                 pixel_mode;
		// When set, palette index 0 is see-through
		logic                        transparency;
		logic [`PPU_W_VADDR-1:0]     tilemap_base;
		logic [`PPU_W_VADDR-1:0]     tileset_base;
	} bg_cfg_t;

	// One paletted output pixel
	typedef struct packed {
		logic                  alpha;
		logic [`PPU_W_PIX-1:0] idx;
	} pixel_t;

endpackage

//--- include/ppu_consts.svh
/*
 * Width and size constants for the background layer of the PPU.
 * Included by both packages and by every RTL module that sizes a
 * port or an array from them. Types built on these live in the
 * packages, not here.
 */
`ifndef PPU_CONSTS_SVH
`define PPU_CONSTS_SVH

// Beam and background coordinates, up to 1024 pixels each way
`define PPU_W_COORD 10

// Holds log2 of a background dimension
`define PPU_W_LOG_COORD 4

// Video memory is word addressed, one 32-bit word per location
`define PPU_W_DATA 32
`define PPU_W_VADDR 10
`define PPU_VRAM_WORDS 1024

// Palette index width of an output pixel
`define PPU_W_PIX 8

// Credits the line consumer grants after reset
`define PPU_OUT_CREDITS 4

`endif
